// File: logic/mbist_settings.svh
`ifndef MBIST_SETTINGS_SVH
`define MBIST_SETTINGS_SVH

// ------------------------------
// microcode store
// ------------------------------
`define MBIST_INST_NUM    16
`define MBIST_PTR_W       4
`define MBIST_INST_W      19

// ------------------------------
// address space with range bottom at 0
// ------------------------------
`define MBIST_ADDR_X_W    2
`define MBIST_ADDR_Y_W    2
`define MBIST_ADDR_X_MAX  3
`define MBIST_ADDR_Y_MAX  3

// ------------------------------
// repeat counter and background
// ------------------------------
`define MBIST_RC_W        4
`define MBIST_RC_MAX      15
`define MBIST_DATA_W      2

`endif

// File: logic/mbist_pkg.sv
`default_nettype none

`include "mbist_settings.svh"

package mbist_pkg;

    // memory operation presented each cycle
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2,
        RMW   = 2'd3
    } op_cmd_t;

    // background pattern type
    typedef enum logic [1:0] {
        BG_SOLID      = 2'd0,
        BG_CHECKER    = 2'd1,
        BG_COL_STRIPE = 2'd2,
        BG_ROW_STRIPE = 2'd3
    } bg_type_t;

    // per-axis address command where CHG steps on the other axis' end
    typedef enum logic [1:0] {
        KEEP = 2'd0,
        INC  = 2'd1,
        DEC  = 2'd2,
        CHG  = 2'd3
    } addr_cmd_t;

    // instruction fields from msb down to op at bit 0
    typedef struct packed {
        logic [`MBIST_PTR_W-1:0] jump_target;
        logic                    loop_en;
        logic                    wait_rc_end;
        logic                    wait_y_end;
        logic                    wait_x_end;
        logic                    rc_step;
        logic                    hold_last;
        addr_cmd_t               y_cmd;
        addr_cmd_t               x_cmd;
        logic                    bg_inv;
        bg_type_t                bg_type;
        op_cmd_t                 op;
    } inst_fields_t;

    // shift chain sees raw bits and decoders see fields
    typedef union packed {
        logic [`MBIST_INST_W-1:0] raw;
        inst_fields_t             fields;
    } inst_word_u;

endpackage

`default_nettype wire

// File: logic/microcode_store.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module microcode_store
    import mbist_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    i_shift_en,
    input  wire logic                    i_shift_in,
    input  wire logic                    i_busy,
    input  wire logic [`MBIST_PTR_W-1:0] i_ptr,
    output inst_word_u                   o_inst
);

    localparam int W = `MBIST_INST_W;

    inst_word_u words [`MBIST_INST_NUM];

    // ------------------------------
    // serial load chain
    // ------------------------------
    // one long chain where word k msb feeds word k+1 bit 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `MBIST_INST_NUM; i++) begin
                words[i].raw <= '0;
            end
        end else if (i_shift_en && !i_busy) begin
            words[0].raw <= {words[0].raw[W-2:0], i_shift_in};
            for (int i = 1; i < `MBIST_INST_NUM; i++) begin
                words[i].raw <= {words[i].raw[W-2:0], words[i-1].raw[W-1]};
            end
        end
    end

    // ------------------------------
    // current word
    // ------------------------------
    // outside a run an all-zero word is shown, which decodes as NOP
    always_comb begin
        o_inst.raw = i_busy ? words[i_ptr].raw : '0;
    end

    // loading must only happen between runs
    a_no_shift_in_run: assert property (
        @(posedge clk) disable iff (!rstn)
        i_shift_en |-> !i_busy
    ) else $error("microcode shift requested during a run");

endmodule

`default_nettype wire

// File: logic/inst_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module inst_sequencer
    import mbist_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    i_run_req,
    input  wire inst_word_u              i_inst,
    input  wire logic                    i_x_end,
    input  wire logic                    i_y_end,
    output logic                         o_run_ack,
    output logic [`MBIST_PTR_W-1:0]      o_ptr,
    output logic                         o_running,
    output logic                         o_start,
    output logic                         o_cond_met
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_RUN  = 2'd1,
        S_DONE = 2'd2
    } seq_state_t;

    localparam logic [`MBIST_RC_W-1:0] RC_MAX = `MBIST_RC_MAX;

    seq_state_t                  state;
    logic [`MBIST_RC_W-1:0]      rc;
    logic [`MBIST_INST_NUM-1:0]  loop_flags;
    logic                        rc_end;
    logic                        take_jump;
    inst_fields_t                f;

    assign f = i_inst.fields;

    // ------------------------------
    // next-instruction condition
    // ------------------------------
    assign rc_end     = (rc == RC_MAX);
    assign o_cond_met = (!f.wait_x_end  || i_x_end) &&
                        (!f.wait_y_end  || i_y_end) &&
                        (!f.wait_rc_end || rc_end);

    // each looping slot jumps back once until the pointer moves past it
    assign take_jump = o_cond_met && f.loop_en && !loop_flags[o_ptr];

    assign o_running = (state == S_RUN);
    assign o_start   = (state == S_IDLE) && i_run_req;
    assign o_run_ack = (state == S_DONE);

    // ------------------------------
    // handshake, pointer, loop flags
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= S_IDLE;
            o_ptr      <= '0;
            rc         <= '0;
            loop_flags <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_run_req) begin
                        state      <= S_RUN;
                        o_ptr      <= '0;
                        rc         <= '0;
                        loop_flags <= '0;
                    end
                end
                S_RUN: begin
                    if (f.op == NOP) begin
                        state <= S_DONE;
                    end else begin
                        if (f.rc_step) begin
                            rc <= rc + 1'b1;
                        end
                        // slots already passed get their flag back
                        for (int i = 0; i < `MBIST_INST_NUM; i++) begin
                            if (i < o_ptr) begin
                                loop_flags[i] <= 1'b0;
                            end
                        end
                        if (take_jump) begin
                            o_ptr             <= f.jump_target;
                            loop_flags[o_ptr] <= 1'b1;
                        end else if (o_cond_met) begin
                            o_ptr <= o_ptr + 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    if (!i_run_req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the environment holds req until ack has been seen
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(o_run_ack) |-> i_run_req
    ) else $error("run ack raised while req is low");

endmodule

`default_nettype wire

// File: logic/addr_gen.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module addr_gen
    import mbist_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_start,
    input  wire logic                       i_step,
    input  wire logic                       i_cond_met,
    input  wire inst_word_u                 i_inst,
    output logic [`MBIST_ADDR_X_W-1:0]      o_addr_x,
    output logic [`MBIST_ADDR_Y_W-1:0]      o_addr_y,
    output logic                            o_x_end,
    output logic                            o_y_end
);

    localparam logic [`MBIST_ADDR_X_W-1:0] X_MAX = `MBIST_ADDR_X_MAX;
    localparam logic [`MBIST_ADDR_Y_W-1:0] Y_MAX = `MBIST_ADDR_Y_MAX;

    addr_cmd_t                    x_dir;
    addr_cmd_t                    y_dir;
    logic                         x_go;
    logic                         y_go;
    logic                         hold;
    logic [`MBIST_ADDR_X_W-1:0]   x_next;
    logic [`MBIST_ADDR_Y_W-1:0]   y_next;

    // a ripple axis borrows the other axis' direction
    function automatic addr_cmd_t axis_dir(input addr_cmd_t cmd, input addr_cmd_t other);
        addr_cmd_t dir;
        dir = cmd;
        if (cmd == CHG) begin
            dir = (other == INC || other == DEC) ? other : KEEP;
        end
        return dir;
    endfunction

    assign x_dir = axis_dir(i_inst.fields.x_cmd, i_inst.fields.y_cmd);
    assign y_dir = axis_dir(i_inst.fields.y_cmd, i_inst.fields.x_cmd);

    // ------------------------------
    // end flags
    // ------------------------------
    assign o_x_end = (x_dir == INC && o_addr_x == X_MAX) || (x_dir == DEC && o_addr_x == '0);
    assign o_y_end = (y_dir == INC && o_addr_y == Y_MAX) || (y_dir == DEC && o_addr_y == '0);

    // last address is kept when the instruction finishes
    assign hold = i_inst.fields.hold_last && i_cond_met;
    assign x_go = !hold && (i_inst.fields.x_cmd != CHG || o_y_end);
    assign y_go = !hold && (i_inst.fields.y_cmd != CHG || o_x_end);

    always_comb begin
        x_next = o_addr_x;
        if (x_go && x_dir == INC) begin
            x_next = o_addr_x + 1'b1;
        end else if (x_go && x_dir == DEC) begin
            x_next = o_addr_x - 1'b1;
        end
    end

    always_comb begin
        y_next = o_addr_y;
        if (y_go && y_dir == INC) begin
            y_next = o_addr_y + 1'b1;
        end else if (y_go && y_dir == DEC) begin
            y_next = o_addr_y - 1'b1;
        end
    end

    // ------------------------------
    // address registers
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_addr_x <= '0;
            o_addr_y <= '0;
        end else if (i_start) begin
            o_addr_x <= '0;
            o_addr_y <= '0;
        end else if (i_step) begin
            o_addr_x <= x_next;
            o_addr_y <= y_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/data_gen.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module data_gen
    import mbist_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_start,
    input  wire logic                       i_step,
    input  wire inst_word_u                 i_inst,
    input  wire logic [`MBIST_ADDR_X_W-1:0] i_addr_x,
    input  wire logic [`MBIST_ADDR_Y_W-1:0] i_addr_y,
    output logic [`MBIST_DATA_W-1:0]        o_data
);

    logic                        flip;
    logic [`MBIST_DATA_W-1:0]    data_next;

    // pattern decides when the background toggles
    always_comb begin
        case (i_inst.fields.bg_type)
            BG_CHECKER:    flip = i_addr_x[0] ^ i_addr_y[0];
            BG_COL_STRIPE: flip = i_addr_y[0];
            BG_ROW_STRIPE: flip = i_addr_x[0];
            default:       flip = 1'b0;
        endcase
    end

    assign data_next = (flip ^ i_inst.fields.bg_inv) ? ~o_data : o_data;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_data <= '0;
        end else if (i_start) begin
            o_data <= '0;
        end else if (i_step) begin
            o_data <= data_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/mbist_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module mbist_top
    import mbist_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_shift_en,
    input  wire logic                       i_shift_in,
    input  wire logic                       i_run_req,
    output logic                            o_run_ack,
    output op_cmd_t                         o_op,
    output logic [`MBIST_ADDR_X_W-1:0]      o_addr_x,
    output logic [`MBIST_ADDR_Y_W-1:0]      o_addr_y,
    output logic [`MBIST_DATA_W-1:0]        o_data
);

    inst_word_u                  cur_inst;
    logic [`MBIST_PTR_W-1:0]     ptr;
    logic                        running;
    logic                        start;
    logic                        cond_met;
    logic                        x_end;
    logic                        y_end;

    // store shows NOP outside a run, so op is taken straight from it
    assign o_op = cur_inst.fields.op;

    microcode_store u_store (
        .clk        (clk),
        .rstn       (rstn),
        .i_shift_en (i_shift_en),
        .i_shift_in (i_shift_in),
        .i_busy     (running),
        .i_ptr      (ptr),
        .o_inst     (cur_inst)
    );

    inst_sequencer u_seq (
        .clk        (clk),
        .rstn       (rstn),
        .i_run_req  (i_run_req),
        .i_inst     (cur_inst),
        .i_x_end    (x_end),
        .i_y_end    (y_end),
        .o_run_ack  (o_run_ack),
        .o_ptr      (ptr),
        .o_running  (running),
        .o_start    (start),
        .o_cond_met (cond_met)
    );

    addr_gen u_addr (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (start),
        .i_step     (running),
        .i_cond_met (cond_met),
        .i_inst     (cur_inst),
        .o_addr_x   (o_addr_x),
        .o_addr_y   (o_addr_y),
        .o_x_end    (x_end),
        .o_y_end    (y_end)
    );

    data_gen u_data (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (start),
        .i_step     (running),
        .i_inst     (cur_inst),
        .i_addr_x   (o_addr_x),
        .i_addr_y   (o_addr_y),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

// File: bench/mbist_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "mbist_settings.svh"

module mbist_tb
    import mbist_pkg::*;
();

    localparam int CLK_HALF = 2;
    localparam int INST_W   = `MBIST_INST_W;
    localparam int INST_NUM = `MBIST_INST_NUM;

    logic                         clk;
    logic                         rstn;
    logic                         i_shift_en;
    logic                         i_shift_in;
    logic                         i_run_req;
    logic                         o_run_ack;
    op_cmd_t                      o_op;
    logic [`MBIST_ADDR_X_W-1:0]   o_addr_x;
    logic [`MBIST_ADDR_Y_W-1:0]   o_addr_y;
    logic [`MBIST_DATA_W-1:0]     o_data;

    // test file image as laid out in bench/mbist_tests.txt
    logic [31:0] tests [0:255];

    int limit = 2000;
    int cycles = 0;
    int seen = 0;
    int run_first = 0;
    int cmd_base = 0;
    int cmd_cnt = 0;
    int cmd_errors = 0;
    int hs_errors = 0;

    mbist_top i_mbist_top (
        .clk        (clk),
        .rstn       (rstn),
        .i_shift_en (i_shift_en),
        .i_shift_in (i_shift_in),
        .i_run_req  (i_run_req),
        .o_run_ack  (o_run_ack),
        .o_op       (o_op),
        .o_addr_x   (o_addr_x),
        .o_addr_y   (o_addr_y),
        .o_data     (o_data)
    );

    always #(CLK_HALF) clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // command checker
    // ------------------------------
    // every non-NOP command is matched in order at mid-cycle
    always @(negedge clk) begin : check_commands
        int         idx;
        logic [7:0] got;
        logic [7:0] exp;
        if (rstn && o_op !== NOP) begin
            idx = seen - run_first;
            got = {o_op, o_addr_x, o_addr_y, o_data};
            if (idx >= cmd_cnt) begin
                $display("error at %0t: extra command %02h beyond the list", $time, got);
                cmd_errors++;
            end else begin
                exp = tests[cmd_base + idx][7:0];
                if (got !== exp) begin
                    $display("error at %0t: command %0d is %02h, expected %02h",
                             $time, idx, got, exp);
                    cmd_errors++;
                end
            end
            seen++;
            if (o_run_ack === 1'b1) begin
                $display("error at %0t: command issued while ack is high", $time);
                cmd_errors++;
            end
        end
    end

    // word 15 goes first and msb first so word 0 lsb enters last
    task automatic load_program(input int base);
        logic [31:0] word;
        for (int w = INST_NUM - 1; w >= 0; w--) begin
            word = tests[base + w];
            for (int b = INST_W - 1; b >= 0; b--) begin
                @(posedge clk);
                #1;
                i_shift_en = 1'b1;
                i_shift_in = word[b];
            end
        end
        @(posedge clk);
        #1;
        i_shift_en = 1'b0;
        i_shift_in = 1'b0;
    endtask

    task automatic run_program(input int base, input int cnt);
        if (o_run_ack !== 1'b0 || o_op !== NOP) begin
            $display("error at %0t: controller not idle before the run request", $time);
            hs_errors++;
        end
        run_first = seen;
        cmd_base  = base;
        cmd_cnt   = cnt;
        i_run_req = 1'b1;
        do begin
            @(negedge clk);
        end while (o_run_ack !== 1'b1);
        if (seen - run_first != cnt) begin
            $display("error at %0t: ack after %0d commands, expected %0d",
                     $time, seen - run_first, cnt);
            hs_errors++;
        end
        // ack holds as long as req stays high
        repeat (2) begin
            @(negedge clk);
            if (o_run_ack !== 1'b1) begin
                $display("error at %0t: ack dropped while req was still high", $time);
                hs_errors++;
            end
        end
        @(posedge clk);
        #1;
        i_run_req = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (o_run_ack !== 1'b0 || o_op !== NOP) begin
            $display("error at %0t: ack did not fall on the edge after req dropped", $time);
            hs_errors++;
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin : main_flow
        int ptr;
        int total;
        int gap;
        int seed_val;
        clk        = 1'b0;
        rstn       = 1'b0;
        i_shift_en = 1'b0;
        i_shift_in = 1'b0;
        i_run_req  = 1'b0;
        seed_val   = $urandom(32'hb1b4);
        $readmemh("bench/mbist_tests.txt", tests);
        total = 0;
        ptr   = 1;
        for (int t = 0; t < tests[0]; t++) begin
            total += tests[ptr + INST_NUM];
            ptr   += INST_NUM + 1 + tests[ptr + INST_NUM];
        end
        limit = total * 4 + 2000;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        ptr  = 1;
        for (int t = 0; t < tests[0]; t++) begin
            load_program(ptr);
            run_program(ptr + INST_NUM + 1, tests[ptr + INST_NUM]);
            ptr += INST_NUM + 1 + tests[ptr + INST_NUM];
            gap = $urandom % 8 + 1;
            repeat (gap) @(posedge clk);
        end
        $display("errors: %0d in commands, %0d in handshake", cmd_errors, hs_errors);
        if (cmd_errors + hs_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/mbist_tests.txt
// first value: number of tests, then per test: 16 instruction words (slot 0 first),
// command count, commands as op[7:6] x[5:4] y[3:2] data[1:0]
5
// write then read, inverted solid background
00011 00002 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
2
40 83
// x increment with y ripple over the whole array, checkerboard
019A5 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
10
40 50 63 73 44 57 67 74 48 58 6B 7B 4C 5F 6F 7C
// inverted row stripe along x, then column stripe along y
0083D 0108A 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
8
40 53 63 70 80 84 8B 8F
// one backward loop jump to slot 0
00021 04022 00003 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
5
40 90 60 B0 C0
// repeat counter ends after 16 steps, last address held
02621 00002 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
11
40 50 60 70 40 50 60 70 40 50 60 70 40 50 60 70 B0

// File: mbist_top.f
+incdir+logic
logic/mbist_pkg.sv
logic/microcode_store.sv
logic/inst_sequencer.sv
logic/addr_gen.sv
logic/data_gen.sv
logic/mbist_top.sv
bench/mbist_tb.sv

// File: Bender.yml
package:
  name: mbist

export_include_dirs:
  - logic

sources:
  - logic/mbist_pkg.sv
  - logic/microcode_store.sv
  - logic/inst_sequencer.sv
  - logic/addr_gen.sv
  - logic/data_gen.sv
  - logic/mbist_top.sv
  - target: test
    files:
      - bench/mbist_tb.sv
